//--- filelist.f
+incdir+rtl
rtl/soc_sys_pkg.sv
rtl/reset_sequencer.sv
rtl/axil_decoder.sv
rtl/sysctl_regs.sv
rtl/axil_sram.sv
rtl/soc_sys_top.sv
verification/soc_sys_checker.sv
verification/soc_sys_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= soc_sys_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/soc_sys_tb.sv
/* drives single-beat AXI4-lite writes and reads from a fixed seed, with random bready/rready.
   SRAM words are written with all strobes first so later partial writes never merge into X. */
`timescale 1ns/10ps

`include "soc_sys_cfg.svh"

module soc_sys_tb
	import soc_sys_pkg::*;
();

	localparam int N_TRANS     = 110;
	localparam int TRANS_BOUND = 40;
	localparam int IDLE_MAX    = 10;
	localparam int ACTIVE_T    = 20;
	localparam int LIMIT_CYC   = N_TRANS * TRANS_BOUND + `SOC_IDLE_DEFAULT + 1
		+ 6 * (ACTIVE_T + IDLE_MAX + 2) + 500;

	logic        core_clk;
	logic        rst_n;
	axil_req_t   bus_req;
	axil_rsp_t   bus_rsp;
	logic [3:0]  led;
	logic        sys_rst_n;
	int          tests;
	int          errors;
	logic [31:0] sram_addr [16];
	logic [31:0] small_idle;

	initial core_clk = 1'b0;
	always #2 core_clk = ~core_clk;

	soc_sys_top soc_sys_top_inst (
		.core_clk    (core_clk),
		.rst_n       (rst_n),
		.i_bus_req   (bus_req),
		.o_bus_rsp   (bus_rsp),
		.o_led       (led),
		.o_sys_rst_n (sys_rst_n)
	);

	soc_sys_checker soc_sys_checker_inst (
		.core_clk    (core_clk),
		.rst_n       (rst_n),
		.i_req       (bus_req),
		.i_rsp       (bus_rsp),
		.i_led       (led),
		.i_sys_rst_n (sys_rst_n),
		.o_tests     (tests),
		.o_errors    (errors)
	);

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(posedge core_clk);
		bus_req.aw.addr <= addr;
		bus_req.aw.id   <= 4'($urandom);
		bus_req.awvalid <= 1'b1;
		do @(negedge core_clk); while (!bus_rsp.awready);
		@(posedge core_clk);
		bus_req.awvalid <= 1'b0;
		bus_req.w.data  <= data;
		bus_req.w.strb  <= strb;
		bus_req.wvalid  <= 1'b1;
		do @(negedge core_clk); while (!bus_rsp.wready);
		@(posedge core_clk);
		bus_req.wvalid <= 1'b0;
		bus_req.bready <= ($urandom_range(3) != 0);
		// random back-pressure until the response is taken
		forever begin
			@(negedge core_clk);
			if (bus_rsp.bvalid && bus_req.bready) break;
			@(posedge core_clk);
			bus_req.bready <= ($urandom_range(3) != 0);
		end
		@(posedge core_clk);
		bus_req.bready <= 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] addr);
		@(posedge core_clk);
		bus_req.ar.addr <= addr;
		bus_req.ar.id   <= 4'($urandom);
		bus_req.arvalid <= 1'b1;
		do @(negedge core_clk); while (!bus_rsp.arready);
		@(posedge core_clk);
		bus_req.arvalid <= 1'b0;
		bus_req.rready  <= ($urandom_range(3) != 0);
		forever begin
			@(negedge core_clk);
			if (bus_rsp.rvalid && bus_req.rready) break;
			@(posedge core_clk);
			bus_req.rready <= ($urandom_range(3) != 0);
		end
		@(posedge core_clk);
		bus_req.rready <= 1'b0;
	endtask

	task automatic wait_sys(input logic level);
		do @(negedge core_clk); while (sys_rst_n !== level);
	endtask

	// watchdog
	initial begin
		#(LIMIT_CYC * 4);
		$display("timeout: run did not finish within %0d cycles", LIMIT_CYC);
		$display("Verification failed");
		$finish;
	end

	initial begin
		void'($urandom(22));
		rst_n   = 1'b0;
		bus_req = '0;
		repeat (3) @(posedge core_clk);
		rst_n <= 1'b1;

		// power-up hold
		wait_sys(1'b1);

		// SRAM, full words first, then random strobes
		for (int i = 0; i < 16; i++) begin
			sram_addr[i] = `SOC_SRAM_BASE + {20'd0, 10'($urandom_range(1023)), 2'b00};
			bus_write(sram_addr[i], $urandom, 4'hF);
		end
		for (int i = 0; i < 32; i++) begin
			bus_write(sram_addr[$urandom_range(15)], $urandom, 4'($urandom));
		end
		for (int i = 0; i < 16; i++) begin
			bus_read(sram_addr[i]);
		end

		// system-control registers
		// byte 0 always enabled and a nonzero nibble so o_led must move
		bus_write(`SOC_SYSCTL_BASE, {28'($urandom), 4'($urandom_range(15, 1))},
			4'($urandom) | 4'h1);
		bus_read(`SOC_SYSCTL_BASE);
		bus_read(`SOC_SYSCTL_BASE + 32'h4);
		bus_read(`SOC_SYSCTL_BASE + 32'h8);
		bus_write(`SOC_SYSCTL_BASE + 32'h10, $urandom, 4'hF);
		bus_read(`SOC_SYSCTL_BASE + 32'h10);

		// unmapped
		bus_write(32'h4000_0000 + {18'd0, 12'($urandom_range(4095)), 2'b00}, $urandom, 4'hF);
		bus_read(32'h4000_0000 + {18'd0, 12'($urandom_range(4095)), 2'b00});

		// software reset with a short idle count
		small_idle = 32'($urandom_range(IDLE_MAX, 3));
		bus_write(`SOC_SYSCTL_BASE + 32'h8, small_idle, 4'hF);
		bus_write(`SOC_SYSCTL_BASE + 32'hC, $urandom, 4'hF);
		wait_sys(1'b0);
		wait_sys(1'b1);
		for (int i = 0; i < 8; i++) begin
			bus_read(sram_addr[i]);
		end
		bus_read(`SOC_SYSCTL_BASE);
		bus_read(`SOC_SYSCTL_BASE + 32'h8);

		// periodic resets from the active count
		bus_write(`SOC_SYSCTL_BASE + 32'h4, ACTIVE_T, 4'hF);
		repeat (3) begin
			wait_sys(1'b0);
			wait_sys(1'b1);
		end
		bus_write(`SOC_SYSCTL_BASE + 32'h4, 32'd0, 4'hF);
		wait_sys(1'b1);

		repeat (20) @(posedge core_clk);
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0 && tests > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- verification/soc_sys_checker.sv
/* passive monitor on the bus, LED and core reset, sampled on the rising clock edge.
   reset periods are skipped after a count is rewritten, since that period has no fixed length. */
`timescale 1ns/10ps

`include "soc_sys_cfg.svh"

module soc_sys_checker
	import soc_sys_pkg::*;
(
	input  logic       core_clk,
	input  logic       rst_n,
	input  axil_req_t  i_req,
	input  axil_rsp_t  i_rsp,
	input  logic [3:0] i_led,
	input  logic       i_sys_rst_n,
	output int         o_tests,
	output int         o_errors
);

	logic [31:0] mem [1024];
	logic [31:0] led_m;
	logic [31:0] idle_m;
	logic [31:0] active_m;
	bit          wr_pend;
	bit          rd_pend;
	logic [31:0] wr_addr;
	logic [3:0]  wr_id;
	logic [31:0] rd_addr;
	logic [3:0]  rd_id;
	logic [31:0] rd_exp;
	logic        prev_sys;
	int          run_cnt;
	bit          skip;
	bit          req_seen;
	bit          ok;

	initial begin
		o_tests  = 0;
		o_errors = 0;
	end

	// 0 SRAM, 1 sysctl, 2 unmapped
	function automatic int target(input logic [31:0] addr);
		if (addr >= `SOC_SRAM_BASE && addr < `SOC_SRAM_BASE + 32'h1000) return 0;
		if (addr >= `SOC_SYSCTL_BASE && addr < `SOC_SYSCTL_BASE + 32'h1000) return 1;
		return 2;
	endfunction

	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	function automatic logic [31:0] model_read(input logic [31:0] addr);
		if (target(addr) == 0) return mem[addr[11:2]];
		if (target(addr) == 2) return 32'd0;
		case (addr[4:2])
			3'd0:    return led_m;
			3'd1:    return active_m;
			3'd2:    return idle_m;
			3'd4:    return `SOC_CORE_ID;
			default: return 32'd0;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
			ok = 1'b0;
		end
	endtask

	task automatic finish_test(input string what);
		o_tests++;
		if (ok) begin
			$display("PASS %s", what);
		end else begin
			o_errors++;
		end
	endtask

	always @(posedge core_clk) begin
		if (!rst_n) begin
			led_m    = 32'd0;
			idle_m   = `SOC_IDLE_DEFAULT;
			active_m = `SOC_ACTIVE_DEFAULT;
			wr_pend  = 1'b0;
			rd_pend  = 1'b0;
			prev_sys = 1'b0;
			run_cnt  = 0;
			skip     = 1'b0;
			req_seen = 1'b0;
		end else begin
			// read captured before any same-edge write, like the SRAM
			if (i_req.arvalid && i_rsp.arready) begin
				rd_pend = 1'b1;
				rd_addr = i_req.ar.addr;
				rd_id   = i_req.ar.id;
				rd_exp  = model_read(i_req.ar.addr);
			end else if (i_rsp.rvalid && i_req.rready) begin
				ok = 1'b1;
				if (!rd_pend) begin
					$display("read data returned with no read outstanding");
					ok = 1'b0;
				end
				compare("r.data", rd_exp, i_rsp.r.data);
				compare("r.id", 32'(rd_id), 32'(i_rsp.r.id));
				compare("r.resp", 32'((target(rd_addr) == 2) ? DECERR : OKAY),
					32'(i_rsp.r.resp));
				finish_test($sformatf("read addr 0x%h id 0x%h", rd_addr, rd_id));
				rd_pend = 1'b0;
			end

			if (i_req.awvalid && i_rsp.awready) begin
				wr_pend = 1'b1;
				wr_addr = i_req.aw.addr;
				wr_id   = i_req.aw.id;
			end
			if (i_req.wvalid && i_rsp.wready) begin
				if (target(wr_addr) == 0) begin
					mem[wr_addr[11:2]] = merge(mem[wr_addr[11:2]], i_req.w.data, i_req.w.strb);
				end else if (target(wr_addr) == 1) begin
					case (wr_addr[4:2])
						3'd0: led_m = merge(led_m, i_req.w.data, i_req.w.strb);
						3'd1: begin
							active_m = merge(active_m, i_req.w.data, i_req.w.strb);
							skip     = 1'b1;
						end
						3'd2: begin
							idle_m = merge(idle_m, i_req.w.data, i_req.w.strb);
							skip   = 1'b1;
						end
						3'd3: req_seen = 1'b1;
						default: ;
					endcase
				end
			end
			if (i_rsp.bvalid && i_req.bready) begin
				ok = 1'b1;
				if (!wr_pend) begin
					$display("write response with no write outstanding");
					ok = 1'b0;
				end
				compare("b.id", 32'(wr_id), 32'(i_rsp.b.id));
				compare("b.resp", 32'((target(wr_addr) == 2) ? DECERR : OKAY),
					32'(i_rsp.b.resp));
				compare("o_led", 32'(led_m[3:0]), 32'(i_led));
				finish_test($sformatf("write addr 0x%h id 0x%h", wr_addr, wr_id));
				wr_pend = 1'b0;
			end

			// core reset period lengths
			if (i_sys_rst_n === prev_sys) begin
				run_cnt++;
			end else begin
				ok = 1'b1;
				if (i_sys_rst_n && !skip) begin
					compare("o_sys_rst_n low cycles", idle_m + 32'd1, run_cnt);
					finish_test($sformatf("core reset held %0d cycles", run_cnt));
				end else if (!i_sys_rst_n && !req_seen) begin
					if (active_m == 0) begin
						$display("o_sys_rst_n fell with no request and no active count");
						ok = 1'b0;
						finish_test("core reset fall");
					end else if (!skip) begin
						compare("o_sys_rst_n high cycles", active_m + 32'd1, run_cnt);
						finish_test($sformatf("core run lasted %0d cycles", run_cnt));
					end
				end
				if (!i_sys_rst_n) req_seen = 1'b0;
				skip     = 1'b0;
				prev_sys = i_sys_rst_n;
				run_cnt  = 1;
			end
		end
	end

endmodule

//--- rtl/soc_sys_top.sv
/* bus master port in, LED and core reset out.
   o_sys_rst_n is low out of rst_n and rises after the idle count. */
`timescale 1ns/10ps

module soc_sys_top
	import soc_sys_pkg::*;
(
	input  logic       core_clk,
	input  logic       rst_n,
	input  axil_req_t  i_bus_req,
	output axil_rsp_t  o_bus_rsp,
	output logic [3:0] o_led,
	output logic       o_sys_rst_n
);

	axil_req_t   sram_req;
	axil_rsp_t   sram_rsp;
	axil_req_t   sysctl_req;
	axil_rsp_t   sysctl_rsp;
	logic [31:0] idle_cnt;
	logic [31:0] active_cnt;
	logic        rst_req;

	axil_decoder axil_decoder_inst (
		.core_clk     (core_clk),
		.rst_n        (rst_n),
		.i_req        (i_bus_req),
		.o_rsp        (o_bus_rsp),
		.o_sram_req   (sram_req),
		.i_sram_rsp   (sram_rsp),
		.o_sysctl_req (sysctl_req),
		.i_sysctl_rsp (sysctl_rsp)
	);

	axil_sram axil_sram_inst (
		.core_clk (core_clk),
		.rst_n    (rst_n),
		.i_req    (sram_req),
		.o_rsp    (sram_rsp)
	);

	// counts and request feed the core reset sequencer
	sysctl_regs sysctl_regs_inst (
		.core_clk     (core_clk),
		.rst_n        (rst_n),
		.i_req        (sysctl_req),
		.o_rsp        (sysctl_rsp),
		.o_led        (o_led),
		.o_idle_cnt   (idle_cnt),
		.o_active_cnt (active_cnt),
		.o_rst_req    (rst_req)
	);

	reset_sequencer reset_sequencer_inst (
		.core_clk     (core_clk),
		.rst_n        (rst_n),
		.i_idle_cnt   (idle_cnt),
		.i_active_cnt (active_cnt),
		.i_rst_req    (rst_req),
		.o_sys_rst_n  (o_sys_rst_n)
	);

endmodule

//--- rtl/axil_sram.sv
/* word array indexed by addr[11:2], contents survive every reset.
   a read and a write to one word in the same cycle return the old word. */
`timescale 1ns/10ps

`include "soc_sys_cfg.svh"

module axil_sram
	import soc_sys_pkg::*;
(
	input  logic      core_clk,
	input  logic      rst_n,
	input  axil_req_t i_req,
	output axil_rsp_t o_rsp
);

	localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

	logic [31:0]      mem [`SOC_SRAM_WORDS];
	slv_wr_state_e    wr_state;
	slv_rd_state_e    rd_state;
	logic [IDX_W-1:0] wr_idx;
	logic [3:0]       wr_id;
	logic [31:0]      rd_data;
	logic [3:0]       rd_id;

	assign o_rsp.awready = (wr_state == W_ADDR);
	assign o_rsp.wready  = (wr_state == W_DATA);
	assign o_rsp.bvalid  = (wr_state == W_RESP);
	assign o_rsp.b.id    = wr_id;
	assign o_rsp.b.resp  = OKAY;
	assign o_rsp.arready = (rd_state == R_ADDR);
	assign o_rsp.rvalid  = (rd_state == R_DATA);
	assign o_rsp.r.data  = rd_data;
	assign o_rsp.r.id    = rd_id;
	assign o_rsp.r.resp  = OKAY;

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			wr_state <= W_ADDR;
			rd_state <= R_ADDR;
		end else begin
			case (wr_state)
				W_ADDR:  wr_state <= i_req.awvalid ? W_DATA : W_ADDR;
				W_DATA:  wr_state <= i_req.wvalid ? W_RESP : W_DATA;
				W_RESP:  wr_state <= i_req.bready ? W_ADDR : W_RESP;
				default: wr_state <= W_ADDR;
			endcase
			case (rd_state)
				R_ADDR:  rd_state <= i_req.arvalid ? R_DATA : R_ADDR;
				default: rd_state <= i_req.rready ? R_ADDR : R_DATA;
			endcase
		end
	end

	// storage and captured payload
	always_ff @(posedge core_clk) begin
		if (wr_state == W_ADDR && i_req.awvalid) begin
			wr_idx <= i_req.aw.addr[IDX_W+1:2];
			wr_id  <= i_req.aw.id;
		end
		if (wr_state == W_DATA && i_req.wvalid) begin
			mem[wr_idx] <= strb_merge(mem[wr_idx], i_req.w);
		end
		if (rd_state == R_ADDR && i_req.arvalid) begin
			rd_data <= mem[i_req.ar.addr[IDX_W+1:2]];
			rd_id   <= i_req.ar.id;
		end
	end

endmodule

//--- rtl/sysctl_regs.sv
/* register select is addr[4:2] only, so the five registers alias every 32 bytes.
   writes to 0xC only pulse the reset request. identity writes are dropped. */
`timescale 1ns/10ps

`include "soc_sys_cfg.svh"

module sysctl_regs
	import soc_sys_pkg::*;
(
	input  logic        core_clk,
	input  logic        rst_n,
	input  axil_req_t   i_req,
	output axil_rsp_t   o_rsp,
	output logic [3:0]  o_led,
	output logic [31:0] o_idle_cnt,
	output logic [31:0] o_active_cnt,
	output logic        o_rst_req
);

	slv_wr_state_e wr_state;
	slv_rd_state_e rd_state;
	logic [2:0]    wr_reg;
	logic [3:0]    wr_id;
	logic [31:0]   rd_data;
	logic [3:0]    rd_id;
	logic [31:0]   led_q;
	logic [31:0]   active_q;
	logic [31:0]   idle_q;

	assign o_rsp.awready = (wr_state == W_ADDR);
	assign o_rsp.wready  = (wr_state == W_DATA);
	assign o_rsp.bvalid  = (wr_state == W_RESP);
	assign o_rsp.b.id    = wr_id;
	assign o_rsp.b.resp  = OKAY;
	assign o_rsp.arready = (rd_state == R_ADDR);
	assign o_rsp.rvalid  = (rd_state == R_DATA);
	assign o_rsp.r.data  = rd_data;
	assign o_rsp.r.id    = rd_id;
	assign o_rsp.r.resp  = OKAY;

	assign o_led        = led_q[3:0];
	assign o_idle_cnt   = idle_q;
	assign o_active_cnt = active_q;

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			wr_state  <= W_ADDR;
			led_q     <= '0;
			active_q  <= `SOC_ACTIVE_DEFAULT;
			idle_q    <= `SOC_IDLE_DEFAULT;
			o_rst_req <= 1'b0;
		end else begin
			// request is a single-cycle strobe
			o_rst_req <= 1'b0;
			case (wr_state)
				W_ADDR: begin
					if (i_req.awvalid) begin
						wr_state <= W_DATA;
					end
				end
				W_DATA: begin
					if (i_req.wvalid) begin
						case (wr_reg)
							3'd0:    led_q <= strb_merge(led_q, i_req.w);
							3'd1:    active_q <= strb_merge(active_q, i_req.w);
							3'd2:    idle_q <= strb_merge(idle_q, i_req.w);
							3'd3:    o_rst_req <= 1'b1;
							default: ;
						endcase
						wr_state <= W_RESP;
					end
				end
				W_RESP: begin
					if (i_req.bready) begin
						wr_state <= W_ADDR;
					end
				end
				default: wr_state <= W_ADDR;
			endcase
		end
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			rd_state <= R_ADDR;
		end else if (rd_state == R_ADDR && i_req.arvalid) begin
			rd_state <= R_DATA;
		end else if (rd_state == R_DATA && i_req.rready) begin
			rd_state <= R_ADDR;
		end
	end

	always_ff @(posedge core_clk) begin
		if (wr_state == W_ADDR && i_req.awvalid) begin
			wr_reg <= i_req.aw.addr[4:2];
			wr_id  <= i_req.aw.id;
		end
		if (rd_state == R_ADDR && i_req.arvalid) begin
			rd_id <= i_req.ar.id;
			case (i_req.ar.addr[4:2])
				3'd0:    rd_data <= led_q;
				3'd1:    rd_data <= active_q;
				3'd2:    rd_data <= idle_q;
				3'd4:    rd_data <= `SOC_CORE_ID;
				default: rd_data <= '0;
			endcase
		end
	end

endmodule

//--- rtl/axil_decoder.sv
/* one master to SRAM and sysctl, one transaction outstanding per direction.
   anything outside both windows is answered here with DECERR and zero read data. */
`timescale 1ns/10ps

`include "soc_sys_cfg.svh"

module axil_decoder
	import soc_sys_pkg::*;
(
	input  logic      core_clk,
	input  logic      rst_n,
	input  axil_req_t i_req,
	output axil_rsp_t o_rsp,
	output axil_req_t o_sram_req,
	input  axil_rsp_t i_sram_rsp,
	output axil_req_t o_sysctl_req,
	input  axil_rsp_t i_sysctl_rsp
);

	typedef enum logic [1:0] {TGT_SRAM, TGT_SYSCTL, TGT_ERR} tgt_e;

	logic       wr_busy;
	logic       rd_busy;
	tgt_e       wr_tgt;
	tgt_e       rd_tgt;
	tgt_e       aw_tgt;
	tgt_e       ar_tgt;
	tgt_e       wr_sel;
	tgt_e       rd_sel;
	logic       aw_fire;
	logic       ar_fire;
	logic       err_w_data;
	logic       err_b_valid;
	logic       err_r_valid;
	logic [3:0] err_w_id;
	logic [3:0] err_r_id;
	axil_rsp_t  err_rsp;
	axil_rsp_t  wr_src;
	axil_rsp_t  rd_src;

	function automatic tgt_e decode(input logic [31:0] addr);
		logic [31:0] sram_off;
		logic [31:0] sys_off;
		sram_off = addr - `SOC_SRAM_BASE;
		sys_off  = addr - `SOC_SYSCTL_BASE;
		if (sram_off < `SOC_SRAM_BYTES) begin
			return TGT_SRAM;
		end
		if (sys_off < `SOC_SYSCTL_BYTES) begin
			return TGT_SYSCTL;
		end
		return TGT_ERR;
	endfunction

	assign aw_tgt = decode(i_req.aw.addr);
	assign ar_tgt = decode(i_req.ar.addr);
	// the registered target holds from address accept to response accept
	assign wr_sel = wr_busy ? wr_tgt : aw_tgt;
	assign rd_sel = rd_busy ? rd_tgt : ar_tgt;
	assign aw_fire = i_req.awvalid && o_rsp.awready;
	assign ar_fire = i_req.arvalid && o_rsp.arready;

	// payloads go to both slaves, only valids and readys are steered
	always_comb begin
		o_sram_req   = i_req;
		o_sysctl_req = i_req;
		o_sram_req.awvalid   = i_req.awvalid && !wr_busy && aw_tgt == TGT_SRAM;
		o_sysctl_req.awvalid = i_req.awvalid && !wr_busy && aw_tgt == TGT_SYSCTL;
		o_sram_req.wvalid    = i_req.wvalid && wr_busy && wr_tgt == TGT_SRAM;
		o_sysctl_req.wvalid  = i_req.wvalid && wr_busy && wr_tgt == TGT_SYSCTL;
		o_sram_req.bready    = i_req.bready && wr_busy && wr_tgt == TGT_SRAM;
		o_sysctl_req.bready  = i_req.bready && wr_busy && wr_tgt == TGT_SYSCTL;
		o_sram_req.arvalid   = i_req.arvalid && !rd_busy && ar_tgt == TGT_SRAM;
		o_sysctl_req.arvalid = i_req.arvalid && !rd_busy && ar_tgt == TGT_SYSCTL;
		o_sram_req.rready    = i_req.rready && rd_busy && rd_tgt == TGT_SRAM;
		o_sysctl_req.rready  = i_req.rready && rd_busy && rd_tgt == TGT_SYSCTL;
	end

	// error responder looks like a slave with the usual channel timing
	always_comb begin
		err_rsp.awready = !wr_busy;
		err_rsp.wready  = err_w_data;
		err_rsp.b.id    = err_w_id;
		err_rsp.b.resp  = DECERR;
		err_rsp.bvalid  = err_b_valid;
		err_rsp.arready = !rd_busy;
		err_rsp.r.data  = '0;
		err_rsp.r.id    = err_r_id;
		err_rsp.r.resp  = DECERR;
		err_rsp.rvalid  = err_r_valid;
	end

	always_comb begin
		case (wr_sel)
			TGT_SRAM:   wr_src = i_sram_rsp;
			TGT_SYSCTL: wr_src = i_sysctl_rsp;
			default:    wr_src = err_rsp;
		endcase
		case (rd_sel)
			TGT_SRAM:   rd_src = i_sram_rsp;
			TGT_SYSCTL: rd_src = i_sysctl_rsp;
			default:    rd_src = err_rsp;
		endcase
		o_rsp.awready = wr_src.awready && !wr_busy;
		o_rsp.wready  = wr_src.wready && wr_busy;
		o_rsp.b       = wr_src.b;
		o_rsp.bvalid  = wr_src.bvalid && wr_busy;
		o_rsp.arready = rd_src.arready && !rd_busy;
		o_rsp.r       = rd_src.r;
		o_rsp.rvalid  = rd_src.rvalid && rd_busy;
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			wr_busy     <= 1'b0;
			rd_busy     <= 1'b0;
			wr_tgt      <= TGT_SRAM;
			rd_tgt      <= TGT_SRAM;
			err_w_data  <= 1'b0;
			err_b_valid <= 1'b0;
			err_r_valid <= 1'b0;
		end else begin
			if (aw_fire) begin
				wr_busy <= 1'b1;
				wr_tgt  <= aw_tgt;
			end else if (o_rsp.bvalid && i_req.bready) begin
				wr_busy <= 1'b0;
			end
			if (ar_fire) begin
				rd_busy <= 1'b1;
				rd_tgt  <= ar_tgt;
			end else if (o_rsp.rvalid && i_req.rready) begin
				rd_busy <= 1'b0;
			end

			// unmapped write: take data, answer on the next cycle
			if (aw_fire && aw_tgt == TGT_ERR) begin
				err_w_data <= 1'b1;
			end else if (err_w_data && i_req.wvalid) begin
				err_w_data <= 1'b0;
			end
			if (err_w_data && i_req.wvalid) begin
				err_b_valid <= 1'b1;
			end else if (err_b_valid && i_req.bready) begin
				err_b_valid <= 1'b0;
			end

			if (ar_fire && ar_tgt == TGT_ERR) begin
				err_r_valid <= 1'b1;
			end else if (err_r_valid && i_req.rready) begin
				err_r_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge core_clk) begin
		if (aw_fire) begin
			err_w_id <= i_req.aw.id;
		end
		if (ar_fire) begin
			err_r_id <= i_req.ar.id;
		end
	end

endmodule

//--- rtl/reset_sequencer.sv
/* system reset stays low for idle+1 cycles, then high until a request or the active count.
   an active count of zero means the cores run until the next software request. */
`timescale 1ns/10ps

module reset_sequencer
	import soc_sys_pkg::*;
(
	input  logic        core_clk,
	input  logic        rst_n,
	input  logic [31:0] i_idle_cnt,
	input  logic [31:0] i_active_cnt,
	input  logic        i_rst_req,
	output logic        o_sys_rst_n
);

	seq_state_e  state;
	logic [31:0] cnt;

	// cores are out of reset only while running
	assign o_sys_rst_n = (state == SEQ_RUN);

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			state <= SEQ_HOLD;
			cnt   <= '0;
		end else begin
			case (state)
				SEQ_HOLD: begin
					// >= so a count lowered mid-period still ends the hold
					if (cnt >= i_idle_cnt) begin
						cnt   <= '0;
						state <= SEQ_RUN;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				SEQ_RUN: begin
					if (i_rst_req) begin
						cnt   <= '0;
						state <= SEQ_HOLD;
					end else if (i_active_cnt != '0 && cnt >= i_active_cnt) begin
						cnt   <= '0;
						state <= SEQ_HOLD;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				default: begin
					cnt   <= '0;
					state <= SEQ_HOLD;
				end
			endcase
		end
	end

endmodule

//--- rtl/soc_sys_pkg.sv
/* bus channel types for the single-beat AXI4-lite fabric, 32-bit data and 4-bit IDs.
   also holds the FSM encodings and the strobe merge shared by the slaves. */
package soc_sys_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		DECERR = 2'b11
	} resp_e;

	typedef enum logic {SEQ_HOLD, SEQ_RUN} seq_state_e;
	typedef enum logic [1:0] {W_ADDR, W_DATA, W_RESP} slv_wr_state_e;
	typedef enum logic {R_ADDR, R_DATA} slv_rd_state_e;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  id;
	} axil_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axil_w_t;

	typedef struct packed {
		logic [3:0] id;
		resp_e      resp;
	} axil_b_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  id;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  id;
		resp_e       resp;
	} axil_r_t;

	// master to slave
	typedef struct packed {
		axil_aw_t aw;
		logic     awvalid;
		axil_w_t  w;
		logic     wvalid;
		logic     bready;
		axil_ar_t ar;
		logic     arvalid;
		logic     rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic     awready;
		logic     wready;
		axil_b_t  b;
		logic     bvalid;
		logic     arready;
		axil_r_t  r;
		logic     rvalid;
	} axil_rsp_t;

	// byte lanes with strb set take the new data
	function automatic logic [31:0] strb_merge(input logic [31:0] old, input axil_w_t w);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (w.strb[b]) begin
				res[8*b +: 8] = w.data[8*b +: 8];
			end
		end
		return res;
	endfunction

endpackage

//--- rtl/soc_sys_cfg.svh
/* address map and power-up defaults for the SRAM and system-control side.
   both windows are 4 KB wide. SRAM depth must stay a power of two. */
`ifndef SOC_SYS_CFG_SVH
`define SOC_SYS_CFG_SVH

// shared SRAM window, word addressed through bits [11:2]
`define SOC_SRAM_BASE      32'h2000_0000
`define SOC_SRAM_WORDS     1024
`define SOC_SRAM_BYTES     (`SOC_SRAM_WORDS * 32'd4)

// system-control register window
`define SOC_SYSCTL_BASE    32'hF100_0000
`define SOC_SYSCTL_BYTES   32'h0000_1000

// reset sequencer counts after power-up
`define SOC_IDLE_DEFAULT   32'd200
// zero disables the active timeout
`define SOC_ACTIVE_DEFAULT 32'd0

`define SOC_CORE_ID        32'hA23D_0C01

`endif
